//--- logic/memCtrl_defines.svh
`ifndef MEMCTRL_DEFINES_SVH
`define MEMCTRL_DEFINES_SVH

// Requester counts
`define CORE_CNT 2
`define DATA_CNT 3

// Bus widths
`define ADDR_W 32
`define DATA_W 64
`define IO_ADDR_W 16
`define LANE_CNT 8

// Data window that maps onto the ROM port
`define ROM_BASE 32'h1000
`define ROM_SIZE 32'h1000

`endif

//--- logic/memCtrlPkg.sv
`include "memCtrl_defines.svh"

package memCtrlPkg;

  // One-hot access size
  // Bit 0 byte, 1 half, 2 word, 3 double, zero means idle
  typedef logic [3:0] accSizeT;

  // One byte enable per lane
  typedef logic [`LANE_CNT-1:0] byteMaskT;

  // One memory word seen at three lane granularities
  typedef union packed {
    logic [`LANE_CNT-1:0][7:0] bytes;
    logic [3:0][15:0] halves;
    logic [1:0][31:0] words;
  } laneWordT;

  // IO port request from one core
  typedef struct packed {
    logic [`IO_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] mosi;
    accSizeT wrSize;
    accSizeT rdSize;
  } ioReqT;

endpackage

//--- logic/memReqIf.sv
`include "memCtrl_defines.svh"

// Selected data access, valid while either size is nonzero
interface memReqIf;

  logic [`ADDR_W-1:0] addr;
  logic [`DATA_W-1:0] mosi;
  memCtrlPkg::accSizeT wrSize;
  memCtrlPkg::accSizeT rdSize;
  logic inRom;

  modport arbiter (
    output addr, mosi, wrSize, rdSize, inRom
  );

  modport aligner (
    input addr, mosi, wrSize, rdSize, inRom
  );

endinterface

//--- logic/accessArbiter.sv
`include "memCtrl_defines.svh"

module accessArbiter (
  input  logic clkH,
  input  logic rst,
  input  logic [`CORE_CNT-1:0] codeReq,
  input  logic [`CORE_CNT-1:0][`ADDR_W-1:0] codeAddr,
  input  logic [`DATA_CNT-1:0][`ADDR_W-1:0] dataAddr,
  input  logic [`DATA_CNT-1:0][`DATA_W-1:0] dataMosi,
  input  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataWrSize,
  input  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataRdSize,
  output logic [`CORE_CNT-1:0] codeAck,
  output logic [`DATA_CNT-1:0] dataAck,
  output logic [`ADDR_W-1:3] romAddr,
  output logic romRdEn,
  output logic [`ADDR_W-1:3] ramAddr,
  memReqIf.arbiter req
);

  logic [`CORE_CNT-1:0] codeGrant;
  logic [`ADDR_W-1:0] codeSelAddr;
  logic [`DATA_CNT-1:0] dataReqV;
  logic [`DATA_CNT-1:0] dataGrant;
  logic [`ADDR_W-1:0] dataSelAddr;
  logic [`DATA_W-1:0] dataSelMosi;
  memCtrlPkg::accSizeT dataSelWrSize;
  memCtrlPkg::accSizeT dataSelRdSize;
  logic dataInRom;

  // **************************************************************************
  // Code fetch
  // **************************************************************************

  // Lowest index wins
  assign codeGrant = codeReq & (~codeReq + 1'b1);

  always_comb begin
    codeSelAddr = '0;
    for (int i = 0; i < `CORE_CNT; i++) begin
      if (codeGrant[i]) begin
        codeSelAddr = codeSelAddr | codeAddr[i];
      end
    end
  end

  // **************************************************************************
  // Data access
  // **************************************************************************

  always_comb begin
    for (int i = 0; i < `DATA_CNT; i++) begin
      dataReqV[i] = (|dataWrSize[i]) | (|dataRdSize[i]);
    end
  end

  assign dataGrant = dataReqV & (~dataReqV + 1'b1);

  // One-hot grant so an OR mux is enough
  always_comb begin
    dataSelAddr = '0;
    dataSelMosi = '0;
    dataSelWrSize = '0;
    dataSelRdSize = '0;
    for (int i = 0; i < `DATA_CNT; i++) begin
      if (dataGrant[i]) begin
        dataSelAddr = dataSelAddr | dataAddr[i];
        dataSelMosi = dataSelMosi | dataMosi[i];
        dataSelWrSize = dataSelWrSize | dataWrSize[i];
        dataSelRdSize = dataSelRdSize | dataRdSize[i];
      end
    end
  end

  // ROM window decode
  assign dataInRom = (|dataGrant) &&
                     (dataSelAddr >= `ROM_BASE) &&
                     (dataSelAddr < (`ROM_BASE + `ROM_SIZE));

  assign req.addr = dataSelAddr;
  assign req.mosi = dataSelMosi;
  assign req.wrSize = dataSelWrSize;
  assign req.rdSize = dataSelRdSize;
  assign req.inRom = dataInRom;

  // **************************************************************************
  // Memory ports
  // **************************************************************************

  // Data in the ROM window steals the ROM port from the fetch
  assign romAddr = dataInRom ? dataSelAddr[`ADDR_W-1:3] : codeSelAddr[`ADDR_W-1:3];
  assign romRdEn = dataInRom ? (|dataSelRdSize) : (|codeGrant);

  assign ramAddr = dataInRom ? '0 : dataSelAddr[`ADDR_W-1:3];

  // Acks one cycle after the grant
  always_ff @(posedge clkH) begin
    if (rst) begin
      codeAck <= '0;
      dataAck <= '0;
    end else begin
      // Lost fetch retries, the core keeps its request
      codeAck <= dataInRom ? '0 : codeGrant;
      dataAck <= dataGrant;
    end
  end

endmodule

//--- logic/laneAligner.sv
`include "memCtrl_defines.svh"

module laneAligner (
  input  logic clkH,
  input  logic rst,
  input  logic [`DATA_W-1:0] romMiso,
  input  logic [`DATA_W-1:0] ramMiso,
  output logic [`DATA_W-1:0] ramMosi,
  output memCtrlPkg::byteMaskT ramWrEn,
  output memCtrlPkg::byteMaskT ramRdEn,
  output logic [`DATA_W-1:0] dataMiso,
  output logic [`DATA_W-1:0] codeMiso,
  memReqIf.aligner req
);

  memCtrlPkg::byteMaskT wrMask;
  memCtrlPkg::byteMaskT rdMask;
  memCtrlPkg::laneWordT wrData;
  memCtrlPkg::laneWordT rdSrc;
  logic [2:0] offQ;
  memCtrlPkg::byteMaskT rdMaskQ;
  logic inRomQ;

  // Size to byte mask, larger sizes cover the smaller ones
  function automatic memCtrlPkg::byteMaskT sizeMask(input memCtrlPkg::accSizeT s);
    return {{4{s[3]}}, {2{|s[3:2]}}, |s[3:1], |s};
  endfunction

  function automatic memCtrlPkg::laneWordT spreadMask(input memCtrlPkg::byteMaskT m);
    memCtrlPkg::laneWordT r;
    for (int i = 0; i < `LANE_CNT; i++) begin
      r.bytes[i] = {8{m[i]}};
    end
    return r;
  endfunction

  // Left lane shift by byte offset, one stage per granularity
  function automatic memCtrlPkg::laneWordT shlLanes(input memCtrlPkg::laneWordT din,
                                                    input logic [2:0] off);
    memCtrlPkg::laneWordT stW;
    memCtrlPkg::laneWordT stH;
    memCtrlPkg::laneWordT stB;
    stW = din;
    if (off[2]) begin
      stW.words = {din.words[0], 32'h0};
    end
    stH = stW;
    if (off[1]) begin
      stH.halves = {stW.halves[2], 16'h0, stW.halves[0], 16'h0};
    end
    stB = stH;
    if (off[0]) begin
      stB.bytes = {stH.bytes[6], 8'h0, stH.bytes[4], 8'h0,
                   stH.bytes[2], 8'h0, stH.bytes[0], 8'h0};
    end
    return stB;
  endfunction

  // Right lane shift back to bit 0
  function automatic memCtrlPkg::laneWordT shrLanes(input memCtrlPkg::laneWordT din,
                                                    input logic [2:0] off);
    memCtrlPkg::laneWordT stW;
    memCtrlPkg::laneWordT stH;
    memCtrlPkg::laneWordT stB;
    stW = din;
    if (off[2]) begin
      stW.words = {32'h0, din.words[1]};
    end
    stH = stW;
    if (off[1]) begin
      stH.halves = {16'h0, stW.halves[3], 16'h0, stW.halves[1]};
    end
    stB = stH;
    if (off[0]) begin
      stB.bytes = {8'h0, stH.bytes[7], 8'h0, stH.bytes[5],
                   8'h0, stH.bytes[3], 8'h0, stH.bytes[1]};
    end
    return stB;
  endfunction

  // **************************************************************************
  // RAM write and read enables
  // **************************************************************************

  assign wrMask = sizeMask(req.wrSize);
  assign rdMask = sizeMask(req.rdSize);
  assign wrData = req.mosi & spreadMask(wrMask);

  assign ramMosi = shlLanes(wrData, req.addr[2:0]);
  assign ramWrEn = req.inRom ? '0 : memCtrlPkg::byteMaskT'(wrMask << req.addr[2:0]);
  assign ramRdEn = req.inRom ? '0 : memCtrlPkg::byteMaskT'(rdMask << req.addr[2:0]);

  always_ff @(posedge clkH) begin
    if (rst) begin
      offQ <= '0;
      rdMaskQ <= '0;
      inRomQ <= 1'b0;
    end else begin
      offQ <= req.addr[2:0];
      rdMaskQ <= rdMask;
      inRomQ <= req.inRom;
    end
  end

  // **************************************************************************
  // Read return
  // **************************************************************************

  assign rdSrc = inRomQ ? romMiso : ramMiso;
  assign dataMiso = shrLanes(rdSrc, offQ) & spreadMask(rdMaskQ);

  // ROM port served the fetch unless data used it last cycle
  assign codeMiso = inRomQ ? '0 : romMiso;

endmodule

//--- logic/ioPortArbiter.sv
`include "memCtrl_defines.svh"

module ioPortArbiter (
  input  logic clkH,
  input  logic rst,
  input  memCtrlPkg::ioReqT [`CORE_CNT-1:0] portReq,
  input  logic [`DATA_W-1:0] ioMiso,
  input  logic ioBusy,
  input  logic ioSrq,
  output logic [`CORE_CNT-1:0] portAck,
  output logic [`DATA_W-1:0] portMiso,
  output logic [`CORE_CNT-1:0] portSrq,
  output logic [`IO_ADDR_W-1:0] ioAddr,
  output logic [`DATA_W-1:0] ioMosi,
  output memCtrlPkg::accSizeT ioWrSize,
  output memCtrlPkg::accSizeT ioRdSize
);

  logic [`CORE_CNT-1:0] portReqV;
  logic [`CORE_CNT-1:0] grantNew;
  memCtrlPkg::ioReqT reqNew;
  memCtrlPkg::ioReqT busReq;
  logic [`CORE_CNT-1:0] grantQ;
  memCtrlPkg::ioReqT reqQ;
  logic busyQ;
  logic keep;
  logic [`CORE_CNT-1:0] grantCur;

  always_comb begin
    for (int i = 0; i < `CORE_CNT; i++) begin
      portReqV[i] = (|portReq[i].wrSize) | (|portReq[i].rdSize);
    end
  end

  assign grantNew = portReqV & (~portReqV + 1'b1);

  always_comb begin
    reqNew = '0;
    for (int i = 0; i < `CORE_CNT; i++) begin
      if (grantNew[i]) begin
        reqNew = reqNew | portReq[i];
      end
    end
  end

  // **************************************************************************
  // Busy hold
  // **************************************************************************

  // Grant moves freely, so freeze it while the device stays busy
  assign keep = busyQ & ioBusy;
  assign grantCur = busyQ ? grantQ : grantNew;

  always_ff @(posedge clkH) begin
    if (rst) begin
      busyQ <= 1'b0;
      grantQ <= '0;
      portAck <= '0;
    end else begin
      busyQ <= ioBusy;
      grantQ <= keep ? grantQ : grantNew;
      portAck <= ioBusy ? '0 : grantCur;
    end
  end

  always_ff @(posedge clkH) begin
    reqQ <= keep ? reqQ : reqNew;
    portMiso <= (ioBusy | ~(|ioRdSize)) ? '0 : ioMiso;
  end

  // Bus side only sees registered busy, no loop through ioBusy
  assign busReq = busyQ ? reqQ : reqNew;
  assign ioAddr = busReq.addr;
  assign ioMosi = busReq.mosi;
  assign ioWrSize = busReq.wrSize;
  assign ioRdSize = busReq.rdSize;

  // Service request goes to the granted core only
  assign portSrq = {`CORE_CNT{~ioBusy & ioSrq}} & grantCur;

endmodule

//--- logic/memCtrl.sv
`include "memCtrl_defines.svh"

module memCtrl (
  input  logic clkH,
  input  logic rst,

  // Code fetch
  input  logic [`CORE_CNT-1:0] codeReq,
  input  logic [`CORE_CNT-1:0][`ADDR_W-1:0] codeAddr,
  output logic [`CORE_CNT-1:0] codeAck,
  output logic [`DATA_W-1:0] codeMiso,

  // Data masters
  input  logic [`DATA_CNT-1:0][`ADDR_W-1:0] dataAddr,
  input  logic [`DATA_CNT-1:0][`DATA_W-1:0] dataMosi,
  input  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataWrSize,
  input  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataRdSize,
  output logic [`DATA_CNT-1:0] dataAck,
  output logic [`DATA_W-1:0] dataMiso,

  // Core IO ports
  input  memCtrlPkg::ioReqT [`CORE_CNT-1:0] portReq,
  output logic [`CORE_CNT-1:0] portAck,
  output logic [`DATA_W-1:0] portMiso,
  output logic [`CORE_CNT-1:0] portSrq,

  // ROM
  output logic [`ADDR_W-1:3] romAddr,
  output logic romRdEn,
  input  logic [`DATA_W-1:0] romMiso,

  // RAM
  output logic [`ADDR_W-1:3] ramAddr,
  output logic [`DATA_W-1:0] ramMosi,
  output memCtrlPkg::byteMaskT ramWrEn,
  output memCtrlPkg::byteMaskT ramRdEn,
  input  logic [`DATA_W-1:0] ramMiso,

  // IO device
  output logic [`IO_ADDR_W-1:0] ioAddr,
  output logic [`DATA_W-1:0] ioMosi,
  output memCtrlPkg::accSizeT ioWrSize,
  output memCtrlPkg::accSizeT ioRdSize,
  input  logic [`DATA_W-1:0] ioMiso,
  input  logic ioBusy,
  input  logic ioSrq
);

  memReqIf dataReq ();

  accessArbiter u_accessArbiter (
    .clkH(clkH),
    .rst(rst),
    .codeReq(codeReq),
    .codeAddr(codeAddr),
    .dataAddr(dataAddr),
    .dataMosi(dataMosi),
    .dataWrSize(dataWrSize),
    .dataRdSize(dataRdSize),
    .codeAck(codeAck),
    .dataAck(dataAck),
    .romAddr(romAddr),
    .romRdEn(romRdEn),
    .ramAddr(ramAddr),
    .req(dataReq.arbiter)
  );

  laneAligner u_laneAligner (
    .clkH(clkH),
    .rst(rst),
    .romMiso(romMiso),
    .ramMiso(ramMiso),
    .ramMosi(ramMosi),
    .ramWrEn(ramWrEn),
    .ramRdEn(ramRdEn),
    .dataMiso(dataMiso),
    .codeMiso(codeMiso),
    .req(dataReq.aligner)
  );

  ioPortArbiter u_ioPortArbiter (
    .clkH(clkH),
    .rst(rst),
    .portReq(portReq),
    .ioMiso(ioMiso),
    .ioBusy(ioBusy),
    .ioSrq(ioSrq),
    .portAck(portAck),
    .portMiso(portMiso),
    .portSrq(portSrq),
    .ioAddr(ioAddr),
    .ioMosi(ioMosi),
    .ioWrSize(ioWrSize),
    .ioRdSize(ioRdSize)
  );

endmodule

//--- verification/memCtrlChecker.sv
`include "memCtrl_defines.svh"

module memCtrlChecker (
  input  logic clkH,
  input  logic armed,
  input  logic [2:0] kind,
  input  logic [1:0] who,
  input  logic [63:0] expVal,
  input  logic [15:0] expAddr,
  input  logic [63:0] expMosi,
  input  logic [`CORE_CNT-1:0] codeAck,
  input  logic [`DATA_W-1:0] codeMiso,
  input  logic [`DATA_CNT-1:0] dataAck,
  input  logic [`DATA_W-1:0] dataMiso,
  input  logic [`CORE_CNT-1:0] portAck,
  input  logic [`DATA_W-1:0] portMiso,
  input  logic [`CORE_CNT-1:0] portSrq,
  input  logic romRdEn,
  input  memCtrlPkg::byteMaskT ramWrEn,
  input  memCtrlPkg::byteMaskT ramRdEn,
  input  logic [`IO_ADDR_W-1:0] ioAddr,
  input  logic [`DATA_W-1:0] ioMosi,
  input  memCtrlPkg::accSizeT ioWrSize,
  input  memCtrlPkg::accSizeT ioRdSize,
  input  logic ioBusy,
  output int errCount
);

  int errAtStart = 0;
  int testsDone = 0;
  int testsFailed = 0;
  logic fired = 1'b0;
  logic busyPrev = 1'b0;

  initial errCount = 0;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic noteFailure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    errCount++;
  endtask

  task automatic endTest(input int id, input logic [63:0] op);
    testsDone++;
    if (errCount != errAtStart) begin
      testsFailed++;
      $display("Test %0d (op %0d): failed with %0d errors", id, op, errCount - errAtStart);
    end else begin
      $display("Test %0d (op %0d): ok", id, op);
    end
    errAtStart = errCount;
  endtask

  task automatic printSummary();
    $display("Summary: %0d tests, %0d failed, %0d errors", testsDone, testsFailed, errCount);
  endtask

  // ************************************************************************
  // Compare on the falling edge where outputs have settled
  // ************************************************************************

  always @(negedge clkH) begin
    if (!armed) begin
      fired = 1'b0;
    end else begin
      case (kind)
        3'd0: if (codeAck[who]) compare("codeMiso", codeMiso, expVal);
        3'd1: begin
          if (dataAck[who]) begin
            compare("dataMiso", dataMiso, expVal);
            // A pending fetch must not be acked alongside
            compare("codeAck", codeAck, 0);
          end
        end
        3'd2: if (!fired) compare("ramWrEn", ramWrEn, expVal);
        3'd4: begin
          // Bus carries the granted request throughout
          compare("ioMosi", ioMosi, expMosi);
          if (ioBusy) begin
            compare("ioAddr", ioAddr, expAddr);
            compare("portAck", portAck, 0);
            compare("portSrq", portSrq, 0);
          end else begin
            compare("portSrq", portSrq, 64'd1 << who);
          end
          // Ack one cycle after the first idle device cycle
          if (fired && !busyPrev) compare("portAck", portAck, 64'd1 << who);
          if (portAck[who]) compare("portMiso", portMiso, expVal);
          busyPrev = ioBusy;
        end
        3'd5: begin
          if (!fired) begin
            compare("idle outputs", {codeAck, dataAck, portAck, romRdEn, ramWrEn,
                                     ramRdEn, ioWrSize, ioRdSize, portSrq}, 0);
          end
        end
        default: ;
      endcase
      fired = 1'b1;
    end
  end

endmodule

//--- verification/tb_memCtrl.sv
`include "memCtrl_defines.svh"

module tb_memCtrl;

  localparam int MAX_LINES = 40;
  localparam int ACK_LIMIT = 20;

  logic clkH;
  logic rst;
  logic [`CORE_CNT-1:0] codeReq;
  logic [`CORE_CNT-1:0][`ADDR_W-1:0] codeAddr;
  logic [`CORE_CNT-1:0] codeAck;
  logic [`DATA_W-1:0] codeMiso;
  logic [`DATA_CNT-1:0][`ADDR_W-1:0] dataAddr;
  logic [`DATA_CNT-1:0][`DATA_W-1:0] dataMosi;
  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataWrSize;
  memCtrlPkg::accSizeT [`DATA_CNT-1:0] dataRdSize;
  logic [`DATA_CNT-1:0] dataAck;
  logic [`DATA_W-1:0] dataMiso;
  memCtrlPkg::ioReqT [`CORE_CNT-1:0] portReq;
  logic [`CORE_CNT-1:0] portAck;
  logic [`DATA_W-1:0] portMiso;
  logic [`CORE_CNT-1:0] portSrq;
  logic [`ADDR_W-1:3] romAddr;
  logic romRdEn;
  logic [`DATA_W-1:0] romMiso;
  logic [`ADDR_W-1:3] ramAddr;
  logic [`DATA_W-1:0] ramMosi;
  memCtrlPkg::byteMaskT ramWrEn;
  memCtrlPkg::byteMaskT ramRdEn;
  logic [`DATA_W-1:0] ramMiso;
  logic [`IO_ADDR_W-1:0] ioAddr;
  logic [`DATA_W-1:0] ioMosi;
  memCtrlPkg::accSizeT ioWrSize;
  memCtrlPkg::accSizeT ioRdSize;
  logic [`DATA_W-1:0] ioMiso;
  logic ioBusy;
  logic ioSrq;

  // Checker control
  logic armed;
  logic [2:0] kind;
  logic [1:0] who;
  logic [63:0] expVal;
  logic [15:0] expAddr;
  logic [63:0] expMosi;
  int errCount;

  logic [63:0] stim [0:MAX_LINES*6-1];
  logic [63:0] ram [0:4095];
  int lineCnt;
  int busyLeft;
  integer seed;
  logic loaded;

  memCtrl u_memCtrl (.*);

  memCtrlChecker chk (.*);

  always #20 clkH = ~clkH;

  // ************************************************************************
  // Memory and device models
  // ************************************************************************

  always @(posedge clkH) begin
    if (romRdEn) romMiso <= {~{3'b000, romAddr}, {3'b000, romAddr}};
  end

  always @(posedge clkH) begin
    for (int b = 0; b < 8; b++) begin
      if (ramWrEn[b]) ram[ramAddr[14:3]][8*b +: 8] <= ramMosi[8*b +: 8];
    end
    if (|ramRdEn) ramMiso <= ram[ramAddr[14:3]];
  end

  // Device word follows the bus address
  assign ioMiso = {ioAddr, ~ioAddr, ioAddr, ~ioAddr};

  // Random filler bytes above the access size
  function automatic logic [63:0] fillMosi(input logic [63:0] d, input logic [3:0] s);
    logic [63:0] m;
    int n;
    m = {$random(seed), $random(seed)};
    n = s[3] ? 8 : s[2] ? 4 : s[1] ? 2 : 1;
    for (int i = 0; i < n; i++) begin
      m[8*i +: 8] = d[8*i +: 8];
    end
    return m;
  endfunction

  // Polls one ack bit and counts down the device busy time
  task automatic waitAck(input int bus, input int r);
    int n;
    logic hit;
    n = 0;
    forever begin
      @(negedge clkH);
      hit = (bus == 0) ? codeAck[r] : (bus == 1) ? dataAck[r] : portAck[r];
      if (hit) return;
      n++;
      if (n >= ACK_LIMIT) begin
        chk.noteFailure($sformatf("no ack for requester %0d within %0d cycles", r, n));
        return;
      end
      @(posedge clkH);
      #2;
      if (busyLeft > 0) busyLeft--;
      ioBusy = (busyLeft != 0);
    end
  endtask

  task automatic runStep(input int idx);
    logic [63:0] op;
    int r;
    logic [63:0] addr;
    logic [3:0] size;
    logic [63:0] data;
    op = stim[idx*6];
    r = stim[idx*6+1];
    addr = stim[idx*6+2];
    size = stim[idx*6+3][3:0];
    data = stim[idx*6+4];
    who = r;
    expVal = stim[idx*6+5];
    expAddr = addr[15:0];
    case (op)
      0: begin
        kind = 3'd5;
        armed = 1'b1;
        @(negedge clkH);
      end
      1: begin
        codeReq[r] = 1'b1;
        codeAddr[r] = addr;
      end
      2: begin
        kind = 3'd0;
        armed = 1'b1;
        waitAck(0, r);
      end
      3: begin
        dataAddr[r] = addr;
        dataRdSize[r] = size;
        kind = 3'd1;
        armed = 1'b1;
        waitAck(1, r);
      end
      4: begin
        dataAddr[r] = addr;
        dataMosi[r] = fillMosi(data, size);
        dataWrSize[r] = size;
        kind = 3'd2;
        armed = 1'b1;
        waitAck(1, r);
      end
      default: begin
        expMosi = {$random(seed), $random(seed)};
        portReq[r] = '{addr: addr[15:0], mosi: expMosi, wrSize: '0, rdSize: size};
        busyLeft = data;
        ioBusy = (busyLeft != 0);
        ioSrq = 1'b1;
        kind = 3'd4;
        armed = 1'b1;
        waitAck(2, r);
      end
    endcase
    if (op != 1) begin
      @(posedge clkH);
      #2;
      armed = 1'b0;
      case (op)
        2: codeReq[r] = 1'b0;
        3: dataRdSize[r] = '0;
        4: dataWrSize[r] = '0;
        5: begin
          portReq[r] = '0;
          ioSrq = 1'b0;
        end
        default: ;
      endcase
      // One idle cycle absorbs the ack of the still held request
      @(posedge clkH);
      #2;
    end
    chk.endTest(idx, op);
  endtask

  initial begin
    for (int i = 0; i < 4096; i++) begin
      ram[i] = {~i, i};
    end
  end

  // Watchdog scaled by the number of stimulus lines
  initial begin
    wait (loaded);
    #((lineCnt * 20 + 16) * 40);
    $display("Watchdog expired, run did not finish in time and was stopped");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clkH = 1'b0;
    rst = 1'b1;
    seed = 32'h7a6d74e2;
    codeReq = '0;
    codeAddr = '0;
    dataAddr = '0;
    dataMosi = '0;
    dataWrSize = '0;
    dataRdSize = '0;
    portReq = '0;
    romMiso = '0;
    ramMiso = '0;
    ioBusy = 1'b0;
    ioSrq = 1'b0;
    armed = 1'b0;
    kind = '0;
    who = '0;
    expVal = '0;
    expAddr = '0;
    expMosi = '0;
    busyLeft = 0;
    lineCnt = 0;
    loaded = 1'b0;
    $readmemh("verification/memCtrl_stimulus.txt", stim);
    while (lineCnt < MAX_LINES && !$isunknown(stim[lineCnt*6])) begin
      lineCnt++;
    end
    loaded = 1'b1;
    repeat (16) @(posedge clkH);
    #2;
    rst = 1'b0;
    for (int i = 0; i < lineCnt; i++) begin
      runStep(i);
    end
    chk.printSummary();
    if (errCount == 0 && lineCnt > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+logic
logic/memCtrlPkg.sv
logic/memReqIf.sv
logic/accessArbiter.sv
logic/laneAligner.sv
logic/ioPortArbiter.sv
logic/memCtrl.sv
verification/memCtrlChecker.sv
verification/tb_memCtrl.sv

//--- verification/memCtrl_stimulus.txt
// op requester address size data expected, all hex
// op 0 idle, 1 raise fetch, 2 fetch ack, 3 data read, 4 data write (expected ramWrEn), 5 IO
0 0 0 0 0 0
1 0 40 0 0 0
1 1 88 0 0 0
2 0 0 0 0 FFFFFFF700000008
2 1 0 0 0 FFFFFFEE00000011
1 0 48 0 0 0
3 1 1004 4 0 00000000FFFFFDFF
2 0 0 0 0 FFFFFFF600000009
4 0 2001 1 AB 02
4 1 2006 1 CD 40
4 2 2103 1 11 08
4 0 2202 2 BEEF 0C
4 1 2206 2 1234 C0
4 0 2300 4 DEADBEEF 0F
4 2 2304 4 CAFEF00D F0
4 1 2400 8 0123456789ABCDEF FF
3 0 2001 1 0 AB
3 2 2006 1 0 CD
3 1 2103 1 0 11
3 0 2202 2 0 BEEF
3 2 2206 2 0 1234
3 1 2300 4 0 DEADBEEF
3 0 2304 4 0 CAFEF00D
3 2 2400 8 0 0123456789ABCDEF
3 1 2300 8 0 CAFEF00DDEADBEEF
5 0 0123 8 3 0123FEDC0123FEDC
5 1 0456 4 0 0456FBA90456FBA9
